// ==== hdl/udp_pkg.sv ====
package udp_pkg;

  // stream geometry
  localparam int data_width_c = 64;                 // bits per beat
  localparam int keep_width_c = data_width_c / 8;   // one enable per byte

  localparam int udp_header_bytes_c = 8;            // fixed udp header size

  typedef logic [31:0] ip_addr_t;       // ipv4, msb is first octet
  typedef logic [15:0] udp_port_t;
  typedef logic [7:0]  word_count_t;    // payload beats per packet
  typedef logic [7:0]  gap_t;           // idle cycles between packets

  // gap codes picked by the push buttons
  localparam gap_t gap_none_c  = 8'd0;  // north
  localparam gap_t gap_short_c = 8'd1;  // center
  localparam gap_t gap_long_c  = 8'd9;  // south

  // one beat on any data stream, 73 bits
  typedef struct packed {
    logic [data_width_c-1:0] data;
    logic [keep_width_c-1:0] keep;
    logic                    last;      // closes the packet
  } stream_beat_t;

  // per-packet descriptor from generator to framer, 104 bits
  typedef struct packed {
    ip_addr_t    dst_ip;
    ip_addr_t    src_ip;
    udp_port_t   dst_port;
    udp_port_t   src_port;
    word_count_t word_count;            // payload only, headers not counted
  } udp_meta_t;

endpackage

// ==== hdl/run_control.sv ====
`timescale 1ns/10ps

module run_control (
  input  logic          aclk,
  input  logic          aresetn,
  input  logic          button_north,
  input  logic          button_center,
  input  logic          button_south,
  input  logic          run_ext,
  input  logic          calib_c0,
  input  logic          calib_c1,
  output logic          run_start,
  output udp_pkg::gap_t packet_gap,
  output logic          link_ready
);
  import udp_pkg::*;

  logic calib_c0_r1;    // first sync stage
  logic calib_c0_r2;
  logic calib_c1_r1;
  logic calib_c1_r2;
  logic any_button;
  logic start_req;

  assign any_button = button_north | button_center | button_south;
  assign start_req  = any_button | run_ext;   // run_ext reuses last gap

  // calibration flags come from the memory clock domains
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      calib_c0_r1 <= 1'b0;
      calib_c0_r2 <= 1'b0;
      calib_c1_r1 <= 1'b0;
      calib_c1_r2 <= 1'b0;
      link_ready  <= 1'b0;
    end else begin
      calib_c0_r1 <= calib_c0;
      calib_c0_r2 <= calib_c0_r1;
      calib_c1_r1 <= calib_c1;
      calib_c1_r2 <= calib_c1_r1;
      link_ready  <= calib_c0_r2 & calib_c1_r2;  // both memories up
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      run_start  <= 1'b0;
      packet_gap <= gap_none_c;
    end else begin
      run_start <= link_ready & start_req;      // single cycle pulse per sample
      if (link_ready) begin
        if (button_south) begin                 // south wins
          packet_gap <= gap_long_c;
        end else if (button_center) begin
          packet_gap <= gap_short_c;
        end else if (button_north) begin
          packet_gap <= gap_none_c;
        end
      end
    end
  end

endmodule

// ==== hdl/udp_traffic_gen.sv ====
`timescale 1ns/10ps

module udp_traffic_gen #(
  parameter udp_pkg::ip_addr_t  LOCAL_IP     = 32'hc0a8_030b,  // 192.168.3.11
  parameter udp_pkg::ip_addr_t  TARGET_IP    = 32'hc0a8_030a,  // 192.168.3.10
  parameter udp_pkg::udp_port_t SRC_PORT     = 16'd49152,
  parameter udp_pkg::udp_port_t DST_PORT     = 16'd5001,
  parameter int unsigned        WORD_COUNT   = 4,
  parameter int unsigned        PACKET_COUNT = 3
) (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic                  run_start,
  input  udp_pkg::gap_t         packet_gap,
  output logic                  busy,
  output logic                  meta_valid,
  output udp_pkg::udp_meta_t    meta,
  input  logic                  meta_ready,
  output logic                  data_valid,
  output udp_pkg::stream_beat_t data,
  input  logic                  data_ready
);
  import udp_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_meta,
    st_payload,
    st_gap
  } state_t;

  state_t      state;
  gap_t        gap_q;      // gap latched at run start
  gap_t        gap_cnt;    // remaining idle cycles
  logic [31:0] pkt_cnt;    // p, upper half of payload
  logic [31:0] word_cnt;   // w, lower half of payload
  logic        last_word;
  logic        last_pkt;

  assign last_word = (word_cnt == WORD_COUNT - 1);
  assign last_pkt  = (pkt_cnt == PACKET_COUNT - 1);
  assign busy      = (state != st_idle);   // new run_start ignored while set

  // descriptor never changes within a run
  assign meta_valid = (state == st_meta);
  assign meta = '{dst_ip: TARGET_IP, src_ip: LOCAL_IP, dst_port: DST_PORT,
                  src_port: SRC_PORT, word_count: word_count_t'(WORD_COUNT)};

  assign data_valid = (state == st_payload);
  assign data = '{data: {pkt_cnt, word_cnt}, keep: '1, last: last_word};

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state    <= st_idle;
      gap_q    <= gap_none_c;
      gap_cnt  <= '0;
      pkt_cnt  <= '0;
      word_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (run_start) begin
            gap_q    <= packet_gap;
            pkt_cnt  <= '0;            // p and w restart every run
            word_cnt <= '0;
            state    <= st_meta;
          end
        end
        st_meta: begin
          if (meta_ready) begin        // meta_valid is high in this state
            state <= st_payload;
          end
        end
        st_payload: begin
          if (data_ready) begin
            if (last_word) begin
              word_cnt <= '0;
              if (last_pkt) begin
                state <= st_idle;      // run done, busy drops
              end else begin
                pkt_cnt <= pkt_cnt + 32'd1;
                if (gap_q == gap_none_c) begin
                  state <= st_meta;    // back to back
                end else begin
                  gap_cnt <= gap_q - gap_t'(1);
                  state   <= st_gap;
                end
              end
            end else begin
              word_cnt <= word_cnt + 32'd1;
            end
          end
        end
        st_gap: begin
          if (gap_cnt == '0) begin     // gap_q cycles spent here
            state <= st_meta;
          end else begin
            gap_cnt <= gap_cnt - gap_t'(1);
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// ==== hdl/stream_fifo.sv ====
`timescale 1ns/10ps

module stream_fifo #(
  parameter type item_t     = logic,
  parameter int  FIFO_DEPTH = 8
) (
  input  logic  aclk,
  input  logic  aresetn,
  input  logic  in_valid,
  input  item_t in_item,
  output logic  in_ready,
  output logic  out_valid,
  output item_t out_item,
  input  logic  out_ready
);

  localparam int ptr_width_c = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int cnt_width_c = $clog2(FIFO_DEPTH + 1);

  typedef logic [ptr_width_c-1:0] ptr_t;
  typedef logic [cnt_width_c-1:0] cnt_t;

  item_t mem [FIFO_DEPTH];   // storage registers
  ptr_t  wr_ptr;
  ptr_t  rd_ptr;
  cnt_t  count;              // occupancy
  logic  push;
  logic  pop;

  // wrap at FIFO_DEPTH, depth need not be a power of two
  function automatic ptr_t next_ptr(input ptr_t ptr);
    if (ptr == ptr_t'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + ptr_t'(1);
  endfunction

  assign in_ready  = (count != cnt_t'(FIFO_DEPTH));  // low when full
  assign out_valid = (count != '0);
  assign out_item  = mem[rd_ptr];                    // straight from a flop
  assign push      = in_valid & in_ready;
  assign pop       = out_valid & out_ready;

  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= in_item;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (push && !pop) begin
        count <= count + cnt_t'(1);
      end else if (pop && !push) begin
        count <= count - cnt_t'(1);
      end
    end
  end

endmodule

// ==== hdl/udp_tx_framer.sv ====
`timescale 1ns/10ps

module udp_tx_framer (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic                  meta_valid,
  input  udp_pkg::udp_meta_t    meta,
  output logic                  meta_ready,
  input  logic                  data_valid,
  input  udp_pkg::stream_beat_t data,
  output logic                  data_ready,
  output logic                  tx_valid,
  output udp_pkg::stream_beat_t tx_data,
  input  logic                  tx_ready,
  output logic [15:0]           tx_packet_count
);
  import udp_pkg::*;

  typedef enum logic [1:0] {
    st_wait_meta,
    st_hdr0,
    st_hdr1,
    st_payload
  } state_t;

  state_t      state;
  udp_meta_t   meta_q;     // descriptor of packet in flight
  logic [15:0] udp_len;    // header plus payload bytes
  logic        tx_fire;

  assign udp_len    = 16'(udp_header_bytes_c) + 16'(meta_q.word_count) * 16'd8;
  assign meta_ready = (state == st_wait_meta);
  assign data_ready = (state == st_payload) & tx_ready;  // pass-through stall
  assign tx_fire    = tx_valid & tx_ready;

  // output mux, header beats built from the held descriptor
  always_comb begin
    tx_valid = 1'b0;
    tx_data  = '0;
    case (state)
      st_hdr0: begin
        tx_valid = 1'b1;
        tx_data  = '{data: {meta_q.dst_ip, meta_q.src_ip}, keep: '1, last: 1'b0};
      end
      st_hdr1: begin
        tx_valid = 1'b1;
        tx_data  = '{data: {meta_q.dst_port, meta_q.src_port, udp_len, 16'h0000},
                     keep: '1, last: 1'b0};   // checksum left at zero
      end
      st_payload: begin
        tx_valid = data_valid;
        tx_data  = data;                      // unchanged
      end
      default: tx_valid = 1'b0;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (meta_valid && meta_ready) begin
      meta_q <= meta;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state           <= st_wait_meta;
      tx_packet_count <= '0;
    end else begin
      case (state)
        st_wait_meta: begin
          if (meta_valid) begin
            state <= st_hdr0;
          end
        end
        st_hdr0: begin
          if (tx_ready) begin
            state <= st_hdr1;
          end
        end
        st_hdr1: begin
          if (tx_ready) begin
            state <= st_payload;
          end
        end
        st_payload: begin
          if (tx_fire && data.last) begin
            state <= st_wait_meta;     // one idle cycle before next meta
          end
        end
        default: state <= st_wait_meta;
      endcase
      if (tx_fire && tx_data.last) begin
        tx_packet_count <= tx_packet_count + 16'd1;
      end
    end
  end

endmodule

// ==== hdl/udp_iperf_top.sv ====
`timescale 1ns/10ps

module udp_iperf_top #(
  parameter udp_pkg::ip_addr_t  LOCAL_IP     = 32'hc0a8_030b,  // 192.168.3.11
  parameter udp_pkg::ip_addr_t  TARGET_IP    = 32'hc0a8_030a,  // 192.168.3.10
  parameter udp_pkg::udp_port_t SRC_PORT     = 16'd49152,
  parameter udp_pkg::udp_port_t DST_PORT     = 16'd5001,
  parameter int unsigned        WORD_COUNT   = 4,
  parameter int unsigned        PACKET_COUNT = 3,
  parameter int                 FIFO_DEPTH   = 8
) (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic                  button_north,
  input  logic                  button_center,
  input  logic                  button_south,
  input  logic                  run_ext,
  input  logic                  calib_c0,
  input  logic                  calib_c1,
  input  logic                  tx_ready,
  output logic                  tx_valid,
  output udp_pkg::stream_beat_t tx_data,
  output logic [15:0]           tx_packet_count,
  output logic                  link_ready,
  output logic                  busy
);
  import udp_pkg::*;

  logic         run_start;
  gap_t         packet_gap;
  logic         gen_meta_valid;   // generator side
  logic         gen_meta_ready;
  udp_meta_t    gen_meta;
  logic         gen_data_valid;
  logic         gen_data_ready;
  stream_beat_t gen_data;
  logic         fr_meta_valid;    // framer side
  logic         fr_meta_ready;
  udp_meta_t    fr_meta;
  logic         fr_data_valid;
  logic         fr_data_ready;
  stream_beat_t fr_data;

  run_control i_run_control (
    .aclk, .aresetn, .button_north, .button_center, .button_south,
    .run_ext, .calib_c0, .calib_c1, .run_start, .packet_gap, .link_ready
  );

  udp_traffic_gen #(
    .LOCAL_IP(LOCAL_IP), .TARGET_IP(TARGET_IP), .SRC_PORT(SRC_PORT),
    .DST_PORT(DST_PORT), .WORD_COUNT(WORD_COUNT), .PACKET_COUNT(PACKET_COUNT)
  ) i_traffic_gen (
    .aclk, .aresetn, .run_start, .packet_gap, .busy,
    .meta_valid(gen_meta_valid), .meta(gen_meta), .meta_ready(gen_meta_ready),
    .data_valid(gen_data_valid), .data(gen_data), .data_ready(gen_data_ready)
  );

  stream_fifo #(.item_t(udp_meta_t), .FIFO_DEPTH(FIFO_DEPTH)) meta_fifo (
    .aclk, .aresetn,
    .in_valid(gen_meta_valid), .in_item(gen_meta), .in_ready(gen_meta_ready),
    .out_valid(fr_meta_valid), .out_item(fr_meta), .out_ready(fr_meta_ready)
  );

  stream_fifo #(.item_t(stream_beat_t), .FIFO_DEPTH(FIFO_DEPTH)) data_fifo (
    .aclk, .aresetn,
    .in_valid(gen_data_valid), .in_item(gen_data), .in_ready(gen_data_ready),
    .out_valid(fr_data_valid), .out_item(fr_data), .out_ready(fr_data_ready)
  );

  udp_tx_framer i_tx_framer (
    .aclk, .aresetn,
    .meta_valid(fr_meta_valid), .meta(fr_meta), .meta_ready(fr_meta_ready),
    .data_valid(fr_data_valid), .data(fr_data), .data_ready(fr_data_ready),
    .tx_valid, .tx_data, .tx_ready, .tx_packet_count
  );

endmodule

// ==== tests/tb_udp_iperf_top.sv ====
`timescale 1ns/10ps

module tb_udp_iperf_top;
  import udp_pkg::*;

  localparam ip_addr_t  local_ip_c     = 32'hc0a8_030b;  // 192.168.3.11
  localparam ip_addr_t  target_ip_c    = 32'hc0a8_030a;  // 192.168.3.10
  localparam udp_port_t src_port_c     = 16'd49152;
  localparam udp_port_t dst_port_c     = 16'd5001;
  localparam int        word_count_c   = 4;
  localparam int        packet_count_c = 3;
  localparam int        beats_pkt_c    = word_count_c + 2;          // two header beats
  localparam int        beats_run_c    = packet_count_c * beats_pkt_c;
  localparam int        runs_c         = 4;
  localparam int        timeout_c      = runs_c * packet_count_c * (word_count_c + 2 + 9) * 4 + 500;

  logic aclk;
  logic aresetn;
  logic button_north;
  logic button_center;
  logic button_south;
  logic run_ext;
  logic calib_c0;
  logic calib_c1;
  logic tx_ready;
  logic tx_valid;
  stream_beat_t tx_data;
  logic [15:0] tx_packet_count;
  logic link_ready;
  logic busy;

  stream_beat_t exp_mem [0:127];   // reference beats in order
  stream_beat_t exp_head;
  int    exp_wr;
  int    exp_rd;
  int    exp_pkt_total;
  int    since_last;               // edges since the last beat with last set
  logic  tx_fire;
  logic  hdr_start;
  logic  random_ready;
  logic  check_long_gap;
  string test_name;

  udp_iperf_top #(
    .LOCAL_IP(local_ip_c), .TARGET_IP(target_ip_c), .SRC_PORT(src_port_c),
    .DST_PORT(dst_port_c), .WORD_COUNT(word_count_c), .PACKET_COUNT(packet_count_c)
  ) i_udp_iperf_top (
    .aclk, .aresetn, .button_north, .button_center, .button_south, .run_ext,
    .calib_c0, .calib_c1, .tx_ready, .tx_valid, .tx_data, .tx_packet_count,
    .link_ready, .busy
  );

  assign tx_fire   = tx_valid & tx_ready;
  assign exp_head  = exp_mem[exp_rd];
  assign hdr_start = (exp_rd % beats_pkt_c == 0) && (exp_rd % beats_run_c != 0);  // not first

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic tick();
    @(posedge aclk);
    #2;
  endtask

  task automatic push_beat(input logic [63:0] d, input logic l);
    exp_mem[exp_wr] = '{data: d, keep: '1, last: l};
    exp_wr++;
  endtask

  // reference model of one run
  task automatic queue_run();
    for (int p = 0; p < packet_count_c; p++) begin
      push_beat({target_ip_c, local_ip_c}, 1'b0);
      push_beat({dst_port_c, src_port_c, 16'(udp_header_bytes_c + 8 * word_count_c), 16'h0},
                1'b0);
      for (int w = 0; w < word_count_c; w++) begin
        push_beat({32'(p), 32'(w)}, w == word_count_c - 1);
      end
    end
    exp_pkt_total += packet_count_c;
  endtask

  task automatic press(input logic n, input logic c, input logic s, input logic e);
    button_north  = n;
    button_center = c;
    button_south  = s;
    run_ext       = e;
    tick();                             // one sample only
    button_north  = 1'b0;
    button_center = 1'b0;
    button_south  = 1'b0;
    run_ext       = 1'b0;
  endtask

  task automatic start_run(input string name, input logic n, input logic c, input logic s,
                           input logic e);
    test_name = name;
    queue_run();
    press(n, c, s, e);
    while (!busy) tick();               // watchdog bounds this
  endtask

  task automatic finish_run();
    while (exp_rd != exp_wr) tick();
    assert (!busy) else report_failure("busy stayed high after the run drained");
    assert (tx_packet_count == 16'(exp_pkt_total))
      else report_failure($sformatf("Fail %s: expected %0d actual %0d", test_name,
                                    exp_pkt_total, tx_packet_count));
  endtask

  always @(posedge aclk) begin
    if (!aresetn) begin
      exp_rd     <= 0;
      since_last <= 0;
    end else begin
      if (tx_fire) exp_rd <= exp_rd + 1;
      since_last <= (tx_fire && tx_data.last) ? 1 : since_last + 1;
    end
  end

  link_low_a: assert property (@(posedge aclk) disable iff (!aresetn)
    !(calib_c0 && calib_c1) |-> !link_ready)
    else report_failure("link_ready high before both calibration flags");
  link_rise_a: assert property (@(posedge aclk) disable iff (!aresetn)
    $rose(calib_c0 && calib_c1) |-> !link_ready ##1 !link_ready ##1 !link_ready ##1 link_ready)
    else report_failure("link_ready did not rise 3 cycles after calibration");
  no_early_tx_a: assert property (@(posedge aclk) disable iff (!aresetn)
    !link_ready |-> !tx_valid) else report_failure("tx_valid seen before link_ready");
  expected_a: assert property (@(posedge aclk) disable iff (!aresetn)
    tx_fire |-> exp_rd < exp_wr) else report_failure("a beat arrived that no run should send");
  beat_a: assert property (@(posedge aclk) disable iff (!aresetn)
    tx_fire |-> tx_data == exp_head)
    else report_failure($sformatf("Fail %s: expected %h actual %h", test_name,
                                  $sampled(exp_head), $sampled(tx_data)));
  hold_a: assert property (@(posedge aclk) disable iff (!aresetn)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
    else report_failure("stalled tx beat changed or dropped valid");
  gap_a: assert property (@(posedge aclk) disable iff (!aresetn)
    tx_fire && hdr_start && check_long_gap |-> since_last >= int'(gap_long_c))
    else report_failure($sformatf("Fail %s: expected gap %0d actual %0d", test_name,
                                  gap_long_c, $sampled(since_last)));

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  initial begin
    void'($urandom(32'he192_0959));
    tx_ready = 1'b1;
    forever begin
      @(posedge aclk);
      #2;
      tx_ready = random_ready ? 1'($urandom) : 1'b1;
    end
  end

  initial begin
    repeat (timeout_c) @(posedge aclk);
    report_failure("the run timed out waiting for the DUT");
  end

  initial begin
    aresetn        = 1'b0;
    button_north   = 1'b0;
    button_center  = 1'b0;
    button_south   = 1'b0;
    run_ext        = 1'b0;
    calib_c0       = 1'b0;
    calib_c1       = 1'b0;
    random_ready   = 1'b0;
    check_long_gap = 1'b0;
    exp_wr         = 0;
    exp_pkt_total  = 0;
    test_name      = "link";
    repeat (4) @(posedge aclk);
    #2;
    aresetn = 1'b1;
    calib_c0 = 1'b1;                    // one memory up, link still down
    repeat (5) tick();
    press(1'b1, 1'b0, 1'b0, 1'b0);      // must be ignored
    repeat (5) tick();
    calib_c1 = 1'b1;
    while (!link_ready) tick();
    tick();
    start_run("north run", 1'b1, 1'b0, 1'b0, 1'b0);
    finish_run();
    check_long_gap = 1'b1;
    start_run("south run", 1'b0, 1'b0, 1'b1, 1'b0);
    finish_run();
    check_long_gap = 1'b0;
    random_ready = 1'b1;                // back-pressure from here
    start_run("center run", 1'b0, 1'b1, 1'b0, 1'b0);
    press(1'b0, 1'b0, 1'b1, 1'b0);      // while busy, adds nothing
    finish_run();
    start_run("external run", 1'b0, 1'b0, 1'b0, 1'b1);
    finish_run();
    random_ready = 1'b0;
    test_name = "idle tail";
    repeat (40) tick();
    finish_run();
    $display("No errors");
    $finish;
  end

endmodule

// ==== files.f ====
hdl/udp_pkg.sv
hdl/run_control.sv
hdl/udp_traffic_gen.sv
hdl/stream_fifo.sv
hdl/udp_tx_framer.sv
hdl/udp_iperf_top.sv
tests/tb_udp_iperf_top.sv

// ==== Bender.yml ====
package:
  name: udp_iperf

sources:
  - files:
      - hdl/udp_pkg.sv
      - hdl/run_control.sv
      - hdl/udp_traffic_gen.sv
      - hdl/stream_fifo.sv
      - hdl/udp_tx_framer.sv
      - hdl/udp_iperf_top.sv
  - target: test
    files:
      - tests/tb_udp_iperf_top.sv
